/* build.f */
src/mcoc_pkg.sv
src/apb_bus_ctrl.sv
src/gpio_port.sv
src/pwm_timer.sv
src/intc_unit.sv
src/mcoc_periph_top.sv
test/tb_checker.sv
test/tb_mcoc_periph.sv

/* Bender.yml */
package:
  name: mcoc_periph

sources:
  - src/mcoc_pkg.sv
  - src/apb_bus_ctrl.sv
  - src/gpio_port.sv
  - src/pwm_timer.sv
  - src/intc_unit.sv
  - src/mcoc_periph_top.sv
  - target: test
    files:
      - test/tb_checker.sv
      - test/tb_mcoc_periph.sv

/* test/tb_mcoc_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mcoc_periph;
	import mcoc_pkg::*;

	localparam logic [2:0] OP_WR = 3'd0; // Write, pslverr_o checked
	localparam logic [2:0] OP_RD = 3'd1; // Read, exact value
	localparam logic [2:0] OP_RDLE = 3'd2; // Read, value at most exp
	localparam logic [2:0] OP_PIN = 3'd3; // Pin group in addr, value in exp
	localparam logic [2:0] OP_DUTY = 3'd4; // PWM high counts {b, a} in exp
	localparam logic [2:0] OP_IDLE = 3'd5;
	localparam logic [15:0] PIN_PORT_O = 16'd0;
	localparam logic [15:0] PIN_PORT_OE = 16'd1;
	localparam logic [15:0] PIN_IRQ = 16'd2;
	localparam logic [15:0] PIN_PWM = 16'd3;
	localparam logic [3:0] UNIT_NONE = 4'd5; // Above the last mapped unit
	localparam int DUTY_LEN = 10; // One timer period

	typedef struct packed {
		logic [7:0] test_no;
		logic [2:0] op;
		logic [15:0] addr;
		logic [15:0] wdata;
		logic [15:0] exp;
		logic err; // pslverr_o expected
		logic [9:0] drive; // {ext_int, port pins}
		logic [7:0] idle; // Wait after the entry
	} step_t;

	logic clk = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_u paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic pready;
	logic pslverr;
	logic [7:0] port_pins;
	logic [7:0] port_out;
	logic [7:0] port_oe;
	logic [1:0] ext_int;
	logic pwm_a;
	logic pwm_b;
	logic irq;
	logic [7:0] tno; // Checker controls
	logic apb_chk, rd_chk, le_chk, pin_chk, duty_chk, exp_err, done;
	logic [1:0] sel;
	logic [15:0] exp_val;
	step_t steps[$];
	logic [7:0] build_test;
	logic [9:0] build_drive;
	logic [15:0] lfsr_st = 16'd59; // Seed
	logic [15:0] w_out, w_enb, w_pin;
	int unsigned len_sum = 0;
	int unsigned cyc = 0;
	int unsigned cyc_limit = 0; // Zero until the table is built

	always #2 clk = ~clk;

	mcoc_periph_top u_dut (
		.clk(clk), .reset_i(reset),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata),
		.prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
		.port_i(port_pins), .port_o(port_out), .port_oe_o(port_oe),
		.ext_int_i(ext_int), .pwm_a_o(pwm_a), .pwm_b_o(pwm_b), .irq_o(irq)
	);

	tb_checker u_chk (
		.clk(clk), .tno_i(tno), .apb_chk_i(apb_chk), .rd_chk_i(rd_chk), .le_chk_i(le_chk),
		.pin_chk_i(pin_chk), .duty_chk_i(duty_chk), .sel_i(sel), .exp_val_i(exp_val),
		.exp_err_i(exp_err), .done_i(done)
	);

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_st = lfsr_next(lfsr_st); // One step per bit
			v = {v[14:0], lfsr_st[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] reg_addr(input logic [3:0] unit, input logic [3:0] idx);
		return {4'h0, unit, 2'b00, idx, 2'b00};
	endfunction

	task automatic add_step(input logic [2:0] op, input logic [15:0] addr,
		input logic [15:0] wdata, input logic [15:0] exp, input logic err, input int idle);
		step_t s;
		s = '{test_no: build_test, op: op, addr: addr, wdata: wdata, exp: exp, err: err,
			drive: build_drive, idle: idle[7:0]};
		len_sum += idle + ((op == OP_PIN) ? 1 : (op == OP_DUTY) ? DUTY_LEN :
			(op == OP_IDLE) ? 0 : 2);
		steps.push_back(s);
	endtask

	task automatic build_table();
		build_drive = '0;
		build_test = 8'd1; // Reset state and identification
		add_step(OP_PIN, PIN_PORT_OE, 0, 16'h0000, 0, 0);
		add_step(OP_PIN, PIN_PORT_O, 0, 16'h0000, 0, 0);
		add_step(OP_PIN, PIN_IRQ, 0, 16'h0000, 0, 0);
		add_step(OP_PIN, PIN_PWM, 0, 16'h0000, 0, 0);
		add_step(OP_RD, reg_addr(UNIT_IDRG, REG_ID_CODE), 0, 16'h1150, 0, 0);
		add_step(OP_RD, reg_addr(UNIT_IDRG, REG_ID_VERS), 0, 16'h0148, 0, 0);
		add_step(OP_RD, reg_addr(UNIT_IDRG, REG_ID_EDIT), 0, 16'h5254, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_IDRG, REG_ID_CODE), take_bits(16), 0, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_IDRG, REG_ID_EDIT), take_bits(16), 0, 0, 0);
		add_step(OP_RD, reg_addr(UNIT_IDRG, REG_ID_CODE), 0, 16'h1150, 0, 0);
		add_step(OP_RD, reg_addr(UNIT_IDRG, REG_ID_EDIT), 0, 16'h5254, 0, 0);
		build_test = 8'd2; // Port
		w_out = take_bits(16);
		w_enb = take_bits(16);
		w_pin = take_bits(8);
		add_step(OP_WR, reg_addr(UNIT_PORT, REG_PORT_OUT), w_out, 0, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_PORT, REG_PORT_ENB), w_enb, 0, 0, 0);
		add_step(OP_PIN, PIN_PORT_O, 0, {8'h00, w_out[7:0]}, 0, 0);
		add_step(OP_PIN, PIN_PORT_OE, 0, {8'h00, w_enb[7:0]}, 0, 0);
		add_step(OP_RD, reg_addr(UNIT_PORT, REG_PORT_OUT), 0, {8'h00, w_out[7:0]}, 0, 0);
		add_step(OP_RD, reg_addr(UNIT_PORT, REG_PORT_ENB), 0, {8'h00, w_enb[7:0]}, 0, 0);
		build_drive = {2'b00, w_pin[7:0]};
		add_step(OP_IDLE, 0, 0, 0, 0, 3); // Two sync flops
		add_step(OP_RD, reg_addr(UNIT_PORT, REG_PORT_INP), 0, {8'h00, w_pin[7:0]}, 0, 0);
		build_test = 8'd3; // Unmapped unit
		add_step(OP_WR, reg_addr(UNIT_NONE, REG_PORT_OUT), ~w_out, 0, 1, 0);
		add_step(OP_RD, reg_addr(UNIT_NONE, REG_PORT_OUT), 0, 16'h0000, 1, 0);
		add_step(OP_RD, reg_addr(UNIT_PORT, REG_PORT_OUT), 0, {8'h00, w_out[7:0]}, 0, 0);
		add_step(OP_PIN, PIN_PORT_O, 0, {8'h00, w_out[7:0]}, 0, 0);
		build_test = 8'd4; // Timer duty, P=9 gives a 10 cycle period
		add_step(OP_WR, reg_addr(UNIT_TIM0, REG_TIM_PERIOD), 16'd9, 0, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_TIM0, REG_TIM_CMPA), 16'd3, 0, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_TIM0, REG_TIM_CMPB), 16'd7, 0, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_TIM0, REG_TIM_CTRL), 16'd1, 0, 0, 20);
		add_step(OP_DUTY, 0, 0, {8'd7, 8'd3}, 0, 0);
		add_step(OP_RDLE, reg_addr(UNIT_TIM0, REG_TIM_COUNT), 0, 16'd9, 0, 0);
		build_test = 8'd5; // Interrupts
		add_step(OP_WR, reg_addr(UNIT_INTC, REG_INTC_ENB), 16'h0004, 0, 0, 12);
		add_step(OP_RD, reg_addr(UNIT_INTC, REG_INTC_PEND), 0, 16'h001C, 0, 0); // All timer events
		add_step(OP_PIN, PIN_IRQ, 0, 16'h0001, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_TIM0, REG_TIM_CTRL), 16'd0, 0, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_INTC, REG_INTC_PEND), 16'h001F, 0, 0, 1);
		add_step(OP_PIN, PIN_IRQ, 0, 16'h0000, 0, 0); // Second edge after the clear
		add_step(OP_RD, reg_addr(UNIT_INTC, REG_INTC_PEND), 0, 16'h0000, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_INTC, REG_INTC_ENB), 16'h0001, 0, 0, 0);
		build_drive[8] = 1'b1; // ext int0 rises
		add_step(OP_IDLE, 0, 0, 0, 0, 5);
		add_step(OP_RD, reg_addr(UNIT_INTC, REG_INTC_PEND), 0, 16'h0001, 0, 0);
		add_step(OP_PIN, PIN_IRQ, 0, 16'h0001, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_INTC, REG_INTC_ENB), 16'h0000, 0, 0, 0);
		add_step(OP_WR, reg_addr(UNIT_INTC, REG_INTC_PEND), 16'h0001, 0, 0, 0);
		build_drive[8] = 1'b0;
		add_step(OP_IDLE, 0, 0, 0, 0, 4);
		build_drive[8] = 1'b1; // Second rising edge, masked
		add_step(OP_IDLE, 0, 0, 0, 0, 6);
		add_step(OP_RD, reg_addr(UNIT_INTC, REG_INTC_PEND), 0, 16'h0001, 0, 0);
		add_step(OP_PIN, PIN_IRQ, 0, 16'h0000, 0, 0);
		cyc_limit = 2 * len_sum + 100;
	endtask

	task automatic apb_transfer(input step_t s);
		psel = 1'b1; // Setup phase
		penable = 1'b0;
		pwrite = (s.op == OP_WR);
		paddr.raw = s.addr;
		pwdata = s.wdata;
		@(negedge clk);
		penable = 1'b1; // Access phase
		apb_chk = 1'b1;
		rd_chk = (s.op == OP_RD);
		le_chk = (s.op == OP_RDLE);
		do begin
			@(posedge clk);
		end while (!pready);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		apb_chk = 1'b0;
		rd_chk = 1'b0;
		le_chk = 1'b0;
	endtask

	task automatic apply_step(input step_t s);
		tno = s.test_no;
		port_pins = s.drive[7:0];
		ext_int = s.drive[9:8];
		exp_val = s.exp;
		exp_err = s.err;
		case (s.op)
			OP_WR, OP_RD, OP_RDLE: apb_transfer(s);
			OP_PIN: begin
				sel = s.addr[1:0];
				pin_chk = 1'b1;
				@(negedge clk);
				pin_chk = 1'b0;
			end
			OP_DUTY: begin
				duty_chk = 1'b1;
				repeat (DUTY_LEN) @(negedge clk);
				duty_chk = 1'b0;
			end
			default: ; // Pin drive only
		endcase
		repeat (s.idle) @(negedge clk);
	endtask

	always @(posedge clk) begin
		cyc++;
		if (cyc_limit != 0 && cyc > cyc_limit) begin
			$display("Timeout: stimulus did not finish within %0d cycles", cyc_limit);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr.raw = '0;
		pwdata = '0;
		port_pins = '0;
		ext_int = '0;
		tno = 8'd0;
		{apb_chk, rd_chk, le_chk, pin_chk, duty_chk, exp_err, done} = '0;
		sel = '0;
		exp_val = '0;
		build_table();
		repeat (10) @(negedge clk);
		reset = 1'b0;
		foreach (steps[i]) apply_step(steps[i]);
		@(negedge clk);
		done = 1'b1; // Checker closes the last test
		@(negedge clk);
		done = 1'b0;
		if (u_chk.err_total == 0 && u_chk.chk_total > 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input logic clk,
	input logic [7:0] tno_i, // Test of the entry being applied
	input logic apb_chk_i, // Access phase under check
	input logic rd_chk_i, // Read data must equal exp_val_i
	input logic le_chk_i, // Read data must not exceed exp_val_i
	input logic pin_chk_i,
	input logic duty_chk_i, // PWM duty window open
	input logic [1:0] sel_i, // Pin group
	input logic [15:0] exp_val_i,
	input logic exp_err_i,
	input logic done_i
);
	wire [15:0] prdata = tb_mcoc_periph.u_dut.prdata_o;
	wire pready = tb_mcoc_periph.u_dut.pready_o;
	wire pslverr = tb_mcoc_periph.u_dut.pslverr_o;
	wire [7:0] port_o = tb_mcoc_periph.u_dut.port_o;
	wire [7:0] port_oe = tb_mcoc_periph.u_dut.port_oe_o;
	wire irq = tb_mcoc_periph.u_dut.irq_o;
	wire pwm_a = tb_mcoc_periph.u_dut.pwm_a_o;
	wire pwm_b = tb_mcoc_periph.u_dut.pwm_b_o;

	int chk_total = 0;
	int err_total = 0;
	int test_chks = 0;
	int test_errs = 0;
	int tests_ok = 0;
	int tests_bad = 0;
	logic [7:0] cur_test = 8'd0;
	logic [15:0] duty_exp = '0; // {b, a} latched at window start
	logic [7:0] duty_a = '0;
	logic [7:0] duty_b = '0;
	logic duty_on = 1'b0;

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		chk_total++;
		test_chks++;
		if (exp !== act) begin
			err_total++;
			test_errs++;
			$display("Fail %s: expected 0x%04h, got 0x%04h in test %0d", name, exp, act, cur_test);
		end
	endtask

	task automatic close_test();
		if (cur_test != 8'd0) begin
			if (test_errs == 0) begin
				tests_ok++;
				$display("Test %0d: all %0d checks ok", cur_test, test_chks);
			end else begin
				tests_bad++;
				$display("Test %0d: %0d of %0d checks wrong", cur_test, test_errs, test_chks);
			end
		end
		test_chks = 0;
		test_errs = 0;
	endtask

	always @(posedge clk) begin
		if (duty_on && !duty_chk_i) begin // Window closed one edge ago
			check_val("pwm_a_o high cycles", {8'h00, duty_exp[7:0]}, {8'h00, duty_a});
			check_val("pwm_b_o high cycles", {8'h00, duty_exp[15:8]}, {8'h00, duty_b});
		end
		if (duty_chk_i && !duty_on) begin
			duty_exp = exp_val_i;
			duty_a = '0;
			duty_b = '0;
		end
		if (duty_chk_i) begin
			duty_a = duty_a + pwm_a; // Pre-edge value of the registered outputs
			duty_b = duty_b + pwm_b;
		end
		duty_on = duty_chk_i;
		if (tno_i != cur_test) begin
			close_test();
			cur_test = tno_i;
		end
		if (apb_chk_i) begin
			check_val("pready_o", 16'h0001, {15'h0000, pready}); // No wait states
			check_val("pslverr_o", {15'h0000, exp_err_i}, {15'h0000, pslverr});
			if (rd_chk_i) check_val("prdata_o", exp_val_i, prdata);
			if (le_chk_i) begin
				chk_total++;
				test_chks++;
				if (prdata > exp_val_i) begin
					err_total++;
					test_errs++;
					$display("Fail prdata_o: expected at most 0x%04h, got 0x%04h in test %0d",
						exp_val_i, prdata, cur_test);
				end
			end
		end
		if (pin_chk_i) begin
			case (sel_i)
				2'd0: check_val("port_o", exp_val_i, {8'h00, port_o});
				2'd1: check_val("port_oe_o", exp_val_i, {8'h00, port_oe});
				2'd2: check_val("irq_o", exp_val_i, {15'h0000, irq});
				default: check_val("pwm_b_o/pwm_a_o", exp_val_i, {14'h0000, pwm_b, pwm_a});
			endcase
		end
		if (done_i) begin
			close_test();
			cur_test = 8'd0;
			$display("Tests ok: %0d, tests with errors: %0d, wrong checks: %0d of %0d",
				tests_ok, tests_bad, err_total, chk_total);
		end
	end

endmodule

`default_nettype wire

/* src/mcoc_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mcoc_periph_top (
	input logic clk,
	input logic reset_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input mcoc_pkg::apb_addr_u paddr_i,
	input logic [mcoc_pkg::DATA_W-1:0] pwdata_i,
	output logic [mcoc_pkg::DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input logic [mcoc_pkg::PORT_W-1:0] port_i,
	output logic [mcoc_pkg::PORT_W-1:0] port_o,
	output logic [mcoc_pkg::PORT_W-1:0] port_oe_o, // Pad ring tri-state control
	input logic [1:0] ext_int_i,
	output logic pwm_a_o,
	output logic pwm_b_o,
	output logic irq_o
);
	import mcoc_pkg::*;

	periph_req_t port_req; // Per-unit request copies
	periph_req_t tim_req;
	periph_req_t intc_req;
	logic [DATA_W-1:0] port_rdata;
	logic [DATA_W-1:0] tim_rdata;
	logic [DATA_W-1:0] intc_rdata;
	tim_evt_t tim_evt; // Timer to interrupt controller

	apb_bus_ctrl u_bus (
		.clk(clk), .reset_i(reset_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
		.port_req_o(port_req), .tim_req_o(tim_req), .intc_req_o(intc_req),
		.port_rdata_i(port_rdata), .tim_rdata_i(tim_rdata), .intc_rdata_i(intc_rdata)
	);

	gpio_port u_port (
		.clk(clk), .reset_i(reset_i), .req_i(port_req), .port_i(port_i),
		.rdata_o(port_rdata), .port_o(port_o), .port_oe_o(port_oe_o)
	);

	pwm_timer u_tim0 (
		.clk(clk), .reset_i(reset_i), .req_i(tim_req),
		.rdata_o(tim_rdata), .pwm_a_o(pwm_a_o), .pwm_b_o(pwm_b_o), .evt_o(tim_evt)
	);

	intc_unit u_intc (
		.clk(clk), .reset_i(reset_i), .req_i(intc_req),
		.ext_int_i(ext_int_i), .tim_evt_i(tim_evt),
		.rdata_o(intc_rdata), .irq_o(irq_o)
	);

endmodule

`default_nettype wire

/* src/intc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module intc_unit (
	input logic clk,
	input logic reset_i,
	input mcoc_pkg::periph_req_t req_i,
	input logic [1:0] ext_int_i,
	input mcoc_pkg::tim_evt_t tim_evt_i,
	output logic [mcoc_pkg::DATA_W-1:0] rdata_o,
	output logic irq_o
);
	import mcoc_pkg::*;

	logic [1:0] ext_s1_q; // First sync stage
	logic [1:0] ext_s2_q; // Synchronised level
	logic [1:0] ext_prev_q; // Level one cycle earlier, for edge detect
	logic [1:0] ext_rise;
	logic [INT_N-1:0] set_vec; // New events this cycle
	logic [INT_N-1:0] clr_vec; // Write-one-to-clear mask
	logic [INT_N-1:0] pend_q;
	logic [INT_N-1:0] enb_q;
	logic irq_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ext_s1_q <= '0;
			ext_s2_q <= '0;
			ext_prev_q <= '0;
		end else begin
			ext_s1_q <= ext_int_i;
			ext_s2_q <= ext_s1_q;
			ext_prev_q <= ext_s2_q;
		end
	end

	assign ext_rise = ext_s2_q & ~ext_prev_q;
	assign set_vec = {tim_evt_i.cmpb, tim_evt_i.cmpa, tim_evt_i.ovf, ext_rise}; // Bit 0 is int0
	assign clr_vec = (req_i.wr && (req_i.idx == REG_INTC_PEND)) ?
		req_i.wdata[INT_N-1:0] : '0;

	// Set wins over a clear of the same bit
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pend_q <= '0;
			enb_q <= '0;
			irq_q <= 1'b0;
		end else begin
			pend_q <= (pend_q & ~clr_vec) | set_vec;
			if (req_i.wr && (req_i.idx == REG_INTC_ENB)) begin
				enb_q <= req_i.wdata[INT_N-1:0];
			end
			irq_q <= |(pend_q & enb_q); // One cycle behind pending
		end
	end

	assign irq_o = irq_q;

	always_comb begin
		case (req_i.idx)
			REG_INTC_PEND: rdata_o = {{(DATA_W-INT_N){1'b0}}, pend_q};
			REG_INTC_ENB: rdata_o = {{(DATA_W-INT_N){1'b0}}, enb_q};
			default: rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/pwm_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_timer (
	input logic clk,
	input logic reset_i,
	input mcoc_pkg::periph_req_t req_i,
	output logic [mcoc_pkg::DATA_W-1:0] rdata_o,
	output logic pwm_a_o,
	output logic pwm_b_o,
	output mcoc_pkg::tim_evt_t evt_o
);
	import mcoc_pkg::*;

	logic run_q; // Counter enable, ctrl bit 0
	logic [DATA_W-1:0] period_q; // Last count before wrap
	logic [DATA_W-1:0] cmpa_q;
	logic [DATA_W-1:0] cmpb_q;
	logic [DATA_W-1:0] count_q; // Running count
	logic wrap; // Count at or past period
	logic pwm_a_q;
	logic pwm_b_q;

	// Also catches a period written below the current count
	assign wrap = (count_q >= period_q);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			run_q <= 1'b0;
			period_q <= '0;
			cmpa_q <= '0;
			cmpb_q <= '0;
		end else if (req_i.wr) begin
			case (req_i.idx)
				REG_TIM_CTRL: run_q <= req_i.wdata[0];
				REG_TIM_PERIOD: period_q <= req_i.wdata;
				REG_TIM_CMPA: cmpa_q <= req_i.wdata;
				REG_TIM_CMPB: cmpb_q <= req_i.wdata;
				default: ; // Count is read only
			endcase
		end
	end

	// Steps 0 .. period, holds while stopped
	always_ff @(posedge clk) begin
		if (reset_i) begin
			count_q <= '0;
		end else if (run_q) begin
			count_q <= wrap ? '0 : count_q + 1'b1;
		end
	end

	// PWM one cycle behind the count, low while stopped
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pwm_a_q <= 1'b0;
			pwm_b_q <= 1'b0;
		end else begin
			pwm_a_q <= run_q & (count_q < cmpa_q);
			pwm_b_q <= run_q & (count_q < cmpb_q);
		end
	end

	assign pwm_a_o = pwm_a_q;
	assign pwm_b_o = pwm_b_q;

	// Event pulses last the one cycle of the matching count
	always_comb begin
		evt_o.ovf = run_q & wrap;
		evt_o.cmpa = run_q & (count_q == cmpa_q);
		evt_o.cmpb = run_q & (count_q == cmpb_q);
	end

	always_comb begin
		case (req_i.idx)
			REG_TIM_CTRL: rdata_o = {{(DATA_W-1){1'b0}}, run_q};
			REG_TIM_PERIOD: rdata_o = period_q;
			REG_TIM_CMPA: rdata_o = cmpa_q;
			REG_TIM_CMPB: rdata_o = cmpb_q;
			REG_TIM_COUNT: rdata_o = count_q; // Live value
			default: rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/gpio_port.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
	input logic clk,
	input logic reset_i,
	input mcoc_pkg::periph_req_t req_i,
	input logic [mcoc_pkg::PORT_W-1:0] port_i,
	output logic [mcoc_pkg::DATA_W-1:0] rdata_o,
	output logic [mcoc_pkg::PORT_W-1:0] port_o,
	output logic [mcoc_pkg::PORT_W-1:0] port_oe_o
);
	import mcoc_pkg::*;

	logic [PORT_W-1:0] out_q; // Output latch
	logic [PORT_W-1:0] enb_q; // Direction, 1 drives the pin
	logic [PORT_W-1:0] sync1_q; // First sync stage
	logic [PORT_W-1:0] sync2_q; // Stable input value

	// Pins float after reset, pad ring sees oe low
	always_ff @(posedge clk) begin
		if (reset_i) begin
			out_q <= '0;
			enb_q <= '0;
		end else if (req_i.wr) begin
			case (req_i.idx)
				REG_PORT_OUT: out_q <= req_i.wdata[PORT_W-1:0];
				REG_PORT_ENB: enb_q <= req_i.wdata[PORT_W-1:0];
				default: ; // Input register is read only
			endcase
		end
	end

	// Two flop synchroniser for asynchronous pins
	always_ff @(posedge clk) begin
		if (reset_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
		end else begin
			sync1_q <= port_i;
			sync2_q <= sync1_q;
		end
	end

	assign port_o = out_q;
	assign port_oe_o = enb_q;

	always_comb begin
		case (req_i.idx)
			REG_PORT_OUT: rdata_o = {{(DATA_W-PORT_W){1'b0}}, out_q};
			REG_PORT_ENB: rdata_o = {{(DATA_W-PORT_W){1'b0}}, enb_q};
			REG_PORT_INP: rdata_o = {{(DATA_W-PORT_W){1'b0}}, sync2_q};
			default: rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/apb_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_bus_ctrl (
	input logic clk,
	input logic reset_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input mcoc_pkg::apb_addr_u paddr_i,
	input logic [mcoc_pkg::DATA_W-1:0] pwdata_i,
	output logic [mcoc_pkg::DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output mcoc_pkg::periph_req_t port_req_o,
	output mcoc_pkg::periph_req_t tim_req_o,
	output mcoc_pkg::periph_req_t intc_req_o,
	input logic [mcoc_pkg::DATA_W-1:0] port_rdata_i,
	input logic [mcoc_pkg::DATA_W-1:0] tim_rdata_i,
	input logic [mcoc_pkg::DATA_W-1:0] intc_rdata_i
);
	import mcoc_pkg::*;

	logic setup_q; // Setup phase seen in the previous cycle
	logic access; // Access phase of a proper transfer
	logic mapped; // Unit exists
	logic wr_stb; // Write to a mapped unit
	logic [UNIT_W-1:0] unit;
	logic [DATA_W-1:0] id_rdata; // Identification read value

	always_ff @(posedge clk) begin
		if (reset_i) begin
			setup_q <= 1'b0;
		end else begin
			setup_q <= psel_i & ~penable_i; // Access must follow a setup
		end
	end

	assign unit = paddr_i.f.unit;
	assign mapped = (unit <= UNIT_INTC);
	assign access = psel_i & penable_i & setup_q;
	assign wr_stb = access & pwrite_i & mapped; // Errored writes are dropped
	assign pready_o = 1'b1; // Zero wait states
	assign pslverr_o = access & ~mapped;

	// Only the addressed unit sees its strobe; ID unit is read only
	always_comb begin
		port_req_o = '{wr: wr_stb && (unit == UNIT_PORT), idx: paddr_i.f.idx, wdata: pwdata_i};
		tim_req_o = '{wr: wr_stb && (unit == UNIT_TIM0), idx: paddr_i.f.idx, wdata: pwdata_i};
		intc_req_o = '{wr: wr_stb && (unit == UNIT_INTC), idx: paddr_i.f.idx, wdata: pwdata_i};
	end

	always_comb begin
		case (paddr_i.f.idx)
			REG_ID_CODE: id_rdata = ID_CODE;
			REG_ID_VERS: id_rdata = ID_VERS;
			REG_ID_EDIT: id_rdata = ID_EDIT; // Edition letters
			default: id_rdata = '0; // Unknown index reads zero
		endcase
	end

	always_comb begin
		case (unit)
			UNIT_IDRG: prdata_o = id_rdata;
			UNIT_PORT: prdata_o = port_rdata_i;
			UNIT_TIM0: prdata_o = tim_rdata_i;
			UNIT_INTC: prdata_o = intc_rdata_i;
			default: prdata_o = '0; // Unmapped unit reads zero
		endcase
	end

endmodule

`default_nettype wire

/* src/mcoc_pkg.sv */
`default_nettype none

package mcoc_pkg;

	localparam int DATA_W = 16; // APB data word
	localparam int ADDR_W = 16; // APB address
	localparam int UNIT_W = 4; // Unit field, addr[11:8]
	localparam int REG_W = 4; // Register index, addr[5:2]
	localparam int PORT_W = 8; // GPIO pins
	localparam int INT_N = 5; // Interrupt sources

	// Unit map
	localparam logic [UNIT_W-1:0] UNIT_IDRG = 4'd0; // Identification
	localparam logic [UNIT_W-1:0] UNIT_PORT = 4'd1; // GPIO port
	localparam logic [UNIT_W-1:0] UNIT_TIM0 = 4'd2; // PWM timer
	localparam logic [UNIT_W-1:0] UNIT_INTC = 4'd3; // Highest mapped unit

	localparam logic [REG_W-1:0] REG_ID_CODE = 4'd0;
	localparam logic [REG_W-1:0] REG_ID_VERS = 4'd1;
	localparam logic [REG_W-1:0] REG_ID_EDIT = 4'd2;
	localparam logic [REG_W-1:0] REG_PORT_OUT = 4'd0; // Output latch
	localparam logic [REG_W-1:0] REG_PORT_ENB = 4'd1; // Output enable per pin
	localparam logic [REG_W-1:0] REG_PORT_INP = 4'd2; // Synchronised pins, read only
	localparam logic [REG_W-1:0] REG_TIM_CTRL = 4'd0; // Bit 0 is run
	localparam logic [REG_W-1:0] REG_TIM_PERIOD = 4'd1;
	localparam logic [REG_W-1:0] REG_TIM_CMPA = 4'd2;
	localparam logic [REG_W-1:0] REG_TIM_CMPB = 4'd3;
	localparam logic [REG_W-1:0] REG_TIM_COUNT = 4'd4; // Read only
	localparam logic [REG_W-1:0] REG_INTC_PEND = 4'd0; // Write ones to clear
	localparam logic [REG_W-1:0] REG_INTC_ENB = 4'd1;

	localparam logic [DATA_W-1:0] ID_CODE = 16'h1150; // Chip code
	localparam logic [DATA_W-1:0] ID_VERS = 16'h0148; // Version 1.48
	localparam logic [DATA_W-1:0] ID_EDIT = 16'h5254; // "RT" in ASCII

	// Field view of an APB address
	typedef struct packed {
		logic [3:0] spare_hi; // addr[15:12], ignored
		logic [UNIT_W-1:0] unit; // addr[11:8]
		logic [1:0] spare; // addr[7:6], ignored
		logic [REG_W-1:0] idx; // addr[5:2]
		logic [1:0] lane; // Byte lane, word access only
	} apb_addr_f_t;

	typedef union packed {
		logic [ADDR_W-1:0] raw; // As driven on the bus
		apb_addr_f_t f; // Decoded fields
	} apb_addr_u;

	typedef struct packed {
		logic wr; // One-cycle write strobe
		logic [REG_W-1:0] idx; // Register index
		logic [DATA_W-1:0] wdata; // Write data
	} periph_req_t;

	typedef struct packed {
		logic ovf; // Counter wrap
		logic cmpa; // Count equals compare A
		logic cmpb; // Count equals compare B
	} tim_evt_t;

endpackage

`default_nettype wire
